/* verilog/adc16_ctrl_pkg.sv */
package adc16_ctrl_pkg;

  // Compile-time identity values reported in the status view of word 0
  localparam logic [1:0] ZDOK_REV    = 2'd2;
  localparam logic [3:0] NUM_UNITS   = 4'd1;
  localparam logic [1:0] CARRIER_REV = 2'd2;

  // ADC chips per board pair, sizes bitslip bus and chip-select field
  localparam int NUM_CHIPS = 8;
  // Delay-reset lines spread over words 2 and 3
  localparam int NUM_DELAY = 64;

  // Word indices, decoded from adr[3:2]
  localparam logic [1:0] REG_CFG3W  = 2'd0;
  localparam logic [1:0] REG_CTRL   = 2'd1;
  localparam logic [1:0] REG_DLY_LO = 2'd2;
  localparam logic [1:0] REG_DLY_HI = 2'd3;

  // Wishbone request from the host
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    // sel[3] enables dat[31:24]
    logic [3:0]  sel;
    logic [31:0] dat;
  } wb_req_t;

  // Wishbone response back to the host
  typedef struct packed {
    logic        ack;
    logic        err;
    logic [31:0] dat;
  } wb_rsp_t;

  // 3-wire serial pins of one ADC board, selects active low
  typedef struct packed {
    logic       sclk;
    logic       sdata;
    logic [3:0] csn;
  } adc3wire_t;

  // Control word, spare bits are plain storage
  typedef struct packed {
    logic [10:0]          spare_31_21;
    logic                 reset;
    logic [2:0]           spare_19_17;
    logic                 snap_req;
    logic [NUM_CHIPS-1:0] bitslip;
    logic [2:0]           spare_7_5;
    logic [4:0]           tap;
  } ctrl_t;

  // Word 0 as it is stored and as it is read back
  typedef union packed {
    struct packed {
      logic [15:0]          rsvd;
      logic [5:0]           spare;
      logic                 sclk;
      logic                 sdata;
      // cs[7] is chip H, cs[0] is chip A
      logic [NUM_CHIPS-1:0] cs;
    } stored;
    struct packed {
      logic [1:0]  zero_31_30;
      logic [1:0]  zdok_rev;
      logic [1:0]  zero_27_26;
      logic [1:0]  locked;
      logic [3:0]  num_units;
      logic [1:0]  zero_19_18;
      logic [1:0]  carrier_rev;
      logic [15:0] low;
    } status;
  } cfg3w_word_u;

endpackage

/* verilog/adc16_strobe_gen.sv */
`timescale 1ns/1ps

module adc16_strobe_gen
  import adc16_ctrl_pkg::*;
(
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  input  logic [NUM_CHIPS-1:0] bitslip_lvl_i,
  input  logic [NUM_DELAY-1:0] dly_rst_lvl_i,
  output logic [NUM_CHIPS-1:0] bitslip_pulse_o,
  output logic [NUM_DELAY-1:0] delay_rst_pulse_o
);

  // All level bits handled as one vector, bitslip in the low bits
  logic [NUM_DELAY+NUM_CHIPS-1:0] lvl;
  logic [NUM_DELAY+NUM_CHIPS-1:0] prev_q;
  logic [NUM_DELAY+NUM_CHIPS-1:0] pulse_q;

  assign lvl = {dly_rst_lvl_i, bitslip_lvl_i};

  // Previous level and rising-edge pulse
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      prev_q  <= '0;
      pulse_q <= '0;
    end else begin
      prev_q  <= lvl;
      // High for one cycle on a 0 to 1 change
      pulse_q <= lvl & ~prev_q;
    end
  end

  // Split back into the two pulse buses
  assign bitslip_pulse_o   = pulse_q[NUM_CHIPS-1:0];
  assign delay_rst_pulse_o = pulse_q[NUM_DELAY+NUM_CHIPS-1:NUM_CHIPS];

endmodule

/* verilog/wb_adc16_regs.sv */
`timescale 1ns/1ps

module wb_adc16_regs
  import adc16_ctrl_pkg::*;
(
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  wb_req_t     req_i,
  input  logic [1:0]  locked_i,
  output wb_rsp_t     rsp_o,
  output logic [15:0] cfg3w_o,
  output ctrl_t       ctrl_o,
  output logic [63:0] dly_rst_o
);

  // Bus handshake state
  logic        ack_q;
  logic        req_take;
  logic [1:0]  word_sel;
  logic [31:0] rdat_q;
  logic [31:0] rdat_next;

  // Register words
  logic [15:0]          cfg3w_q;
  ctrl_t                ctrl_q;
  logic [NUM_DELAY-1:0] dly_q;

  // Lock synchronizer stages
  logic [1:0] lock_meta_q;
  logic [1:0] lock_sync_q;

  // Word 0 as seen by a read
  cfg3w_word_u status_w;

  // Merge write data into a word, one byte lane per sel bit
  function automatic logic [31:0] merge_bytes(
    input logic [31:0] old_word,
    input logic [31:0] wr_data,
    input logic [3:0]  sel
  );
    logic [31:0] result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        result[b*8 +: 8] = wr_data[b*8 +: 8];
      end
    end
    return result;
  endfunction

  // New request only while no ack is outstanding
  assign req_take = req_i.cyc & req_i.stb & ~ack_q;
  assign word_sel = req_i.adr[3:2];

  // Status view of word 0
  always_comb begin
    status_w                    = '0;
    status_w.status.zdok_rev    = ZDOK_REV;
    status_w.status.locked      = lock_sync_q;
    status_w.status.num_units   = NUM_UNITS;
    status_w.status.carrier_rev = CARRIER_REV;
    status_w.status.low         = cfg3w_q;
  end

  // Read-back mux
  always_comb begin
    case (word_sel)
      REG_CFG3W:  rdat_next = status_w;
      REG_CTRL:   rdat_next = ctrl_q;
      REG_DLY_LO: rdat_next = dly_q[31:0];
      default:    rdat_next = dly_q[63:32];
    endcase
  end

  // Ack is a single-cycle pulse after each taken request
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req_take;
    end
  end

  // Register writes land on the edge that raises ack
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      cfg3w_q <= '0;
      ctrl_q  <= '0;
      dly_q   <= '0;
    end else if (req_take && req_i.we) begin
      case (word_sel)
        REG_CFG3W: begin
          // Only the two low lanes are writable
          cfg3w_q <= 16'(merge_bytes({16'h0000, cfg3w_q}, req_i.dat, req_i.sel));
        end
        REG_CTRL: begin
          ctrl_q <= ctrl_t'(merge_bytes(ctrl_q, req_i.dat, req_i.sel));
        end
        REG_DLY_LO: begin
          dly_q[31:0] <= merge_bytes(dly_q[31:0], req_i.dat, req_i.sel);
        end
        default: begin
          // Upper half of the delay-reset lines
          dly_q[63:32] <= merge_bytes(dly_q[63:32], req_i.dat, req_i.sel);
        end
      endcase
    end
  end

  // Read data is captured with the request
  always_ff @(posedge wb_clk_i) begin
    if (req_take && !req_i.we) begin
      rdat_q <= rdat_next;
    end
  end

  // Two-flop synchronizer for the line-clock lock flags
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      lock_meta_q <= '0;
      lock_sync_q <= '0;
    end else begin
      lock_meta_q <= locked_i;
      lock_sync_q <= lock_meta_q;
    end
  end

  // Response, data forced to zero outside ack
  assign rsp_o = '{
    ack: ack_q,
    err: 1'b0,
    dat: ack_q ? rdat_q : 32'h0000_0000
  };

  assign cfg3w_o   = cfg3w_q;
  assign ctrl_o    = ctrl_q;
  assign dly_rst_o = dly_q;

endmodule

/* verilog/adc16_ctrl_top.sv */
`timescale 1ns/1ps

module adc16_ctrl_top
  import adc16_ctrl_pkg::*;
(
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  input  wb_req_t              wb_req_i,
  output wb_rsp_t              wb_rsp_o,
  input  logic [1:0]           adc_locked_i,
  output adc3wire_t            adc0_3w_o,
  output adc3wire_t            adc1_3w_o,
  output logic                 adc_reset_o,
  output logic                 snap_req_o,
  output logic [4:0]           delay_tap_o,
  output logic [NUM_CHIPS-1:0] bitslip_o,
  output logic [NUM_DELAY-1:0] delay_rst_o
);

  // Register block outputs
  logic [15:0]          cfg3w;
  ctrl_t                ctrl;
  logic [NUM_DELAY-1:0] dly_rst;

  // Stored view of word 0 for the pin fan-out
  cfg3w_word_u cfg_w;

  wb_adc16_regs regs_i (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .req_i     (wb_req_i),
    .locked_i  (adc_locked_i),
    .rsp_o     (wb_rsp_o),
    .cfg3w_o   (cfg3w),
    .ctrl_o    (ctrl),
    .dly_rst_o (dly_rst)
  );

  // Bitslip and delay-reset levels become single pulses
  adc16_strobe_gen strobe_i (
    .wb_clk_i          (wb_clk_i),
    .wb_rst_i          (wb_rst_i),
    .bitslip_lvl_i     (ctrl.bitslip),
    .dly_rst_lvl_i     (dly_rst),
    .bitslip_pulse_o   (bitslip_o),
    .delay_rst_pulse_o (delay_rst_o)
  );

  assign cfg_w = {16'h0000, cfg3w};

  // Both boards share clock and data
  assign adc0_3w_o.sclk  = cfg_w.stored.sclk;
  assign adc0_3w_o.sdata = cfg_w.stored.sdata;
  assign adc1_3w_o.sclk  = cfg_w.stored.sclk;
  assign adc1_3w_o.sdata = cfg_w.stored.sdata;

  // Selects stored active high, pins active low
  // Board 0 takes chips A to D, board 1 chips E to H
  assign adc0_3w_o.csn = ~cfg_w.stored.cs[3:0];
  assign adc1_3w_o.csn = ~cfg_w.stored.cs[7:4];

  // Level controls straight from the control word
  assign adc_reset_o = ctrl.reset;
  assign snap_req_o  = ctrl.snap_req;
  assign delay_tap_o = ctrl.tap;

endmodule

/* verification/adc16_ctrl_props.sv */
`timescale 1ns/1ps

module adc16_ctrl_props
  import adc16_ctrl_pkg::*;
(
  input logic                 clk_i,
  input logic                 rst_i,
  input wb_rsp_t              rsp_i,
  input adc3wire_t            adc0_i,
  input adc3wire_t            adc1_i,
  input logic [15:0]          cfg3w_i,
  input logic [NUM_CHIPS-1:0] bitslip_i,
  input logic [NUM_DELAY-1:0] dly_rst_i
);

  // Ack is a single-cycle pulse
  assert property (@(posedge clk_i) disable iff (rst_i) rsp_i.ack |=> !rsp_i.ack)
    else $error("ack held high for two cycles");

  // No error responses in this slave
  assert property (@(posedge clk_i) !rsp_i.err)
    else $error("err went high");

  // Pins are the inverted stored selects, chips A to D on board 0
  assert property (@(posedge clk_i)
    adc0_i.csn == ~cfg3w_i[3:0] && adc1_i.csn == ~cfg3w_i[7:4])
    else $error("chip-select pins do not match stored selects");

  // Every strobe lasts one cycle only
  assert property (@(posedge clk_i) disable iff (rst_i)
    ({dly_rst_i, bitslip_i} & $past({dly_rst_i, bitslip_i})) == '0)
    else $error("strobe high for two consecutive cycles");

endmodule

bind adc16_ctrl_top adc16_ctrl_props props_i (
  .clk_i     (wb_clk_i),
  .rst_i     (wb_rst_i),
  .rsp_i     (wb_rsp_o),
  .adc0_i    (adc0_3w_o),
  .adc1_i    (adc1_3w_o),
  .cfg3w_i   (cfg3w),
  .bitslip_i (bitslip_o),
  .dly_rst_i (delay_rst_o)
);

/* verification/adc16_ctrl_tb.sv */
`timescale 1ns/1ps

module adc16_ctrl_tb
  import adc16_ctrl_pkg::*;
;

  localparam int MAX_ENTRIES = 96;
  localparam logic [1:0] LOCK_VAL = 2'b10;

  // One table row, op 1 is a write
  typedef struct packed {
    logic        wr;
    logic [1:0]  word;
    logic [3:0]  sel;
    logic [31:0] data;
    logic [31:0] exp;
  } entry_t;

  logic                 wb_clk_i;
  logic                 wb_rst_i;
  wb_req_t              req;
  wb_rsp_t              rsp;
  logic [1:0]           adc_locked;
  adc3wire_t            adc0;
  adc3wire_t            adc1;
  logic                 adc_reset;
  logic                 snap_req;
  logic [4:0]           delay_tap;
  logic [NUM_CHIPS-1:0] bitslip;
  logic [NUM_DELAY-1:0] delay_rst;

  entry_t      table_q [MAX_ENTRIES];
  int          n_entries;
  int          cycle_limit;
  int          cycles;
  logic [31:0] lfsr_state;
  // Build-time and run-time register models, word 0 keeps only 15:0
  logic [31:0] build_w [4];
  logic [31:0] run_w [4];
  int          pulse_cnt [NUM_DELAY+NUM_CHIPS];
  int          exp_cnt [NUM_DELAY+NUM_CHIPS];
  // All pulse outputs, bitslip in the low bits
  logic [NUM_DELAY+NUM_CHIPS-1:0] pulse_vec;

  adc16_ctrl_top dut_i (
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .wb_req_i     (req),
    .wb_rsp_o     (rsp),
    .adc_locked_i (adc_locked),
    .adc0_3w_o    (adc0),
    .adc1_3w_o    (adc1),
    .adc_reset_o  (adc_reset),
    .snap_req_o   (snap_req),
    .delay_tap_o  (delay_tap),
    .bitslip_o    (bitslip),
    .delay_rst_o  (delay_rst)
  );

  assign pulse_vec = {delay_rst, bitslip};

  // 20 ns clock
  initial wb_clk_i = 1'b0;
  always #10 wb_clk_i = ~wb_clk_i;

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_now($sformatf("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_pins(input string name, input adc3wire_t got, input adc3wire_t exp);
    if (got !== exp) begin
      fail_now($sformatf("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  // Level outputs against the expected control word
  task automatic check_ctrl(input ctrl_t exp);
    check_word("adc_reset_o", {31'd0, adc_reset}, {31'd0, exp.reset});
    check_word("snap_req_o", {31'd0, snap_req}, {31'd0, exp.snap_req});
    check_word("delay_tap_o", {27'd0, delay_tap}, {27'd0, exp.tap});
  endtask

  // Galois LFSR, one step per random bit
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    for (int i = 0; i < 32; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      w[i] = lfsr_state[0];
    end
    return w;
  endfunction

  // Enabled bytes take the new data
  function automatic logic [31:0] lane_merge(input logic [31:0] old_w, input logic [31:0] d,
                                             input logic [3:0] sel);
    logic [31:0] mask;
    mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    return (old_w & ~mask) | (d & mask);
  endfunction

  // Status positions: ZDOK 29:28, lock 25:24, units 23:20, carrier 17:16
  function automatic logic [31:0] status_word(input logic [15:0] low);
    return {2'b00, ZDOK_REV, 2'b00, LOCK_VAL, NUM_UNITS, 2'b00, CARRIER_REV, low};
  endfunction

  task automatic add_entry(input logic wr, input logic [1:0] word, input logic [3:0] sel,
                           input logic [31:0] data);
    entry_t e;
    e = '{wr: wr, word: word, sel: sel, data: data, exp: 32'h0};
    if (wr) begin
      build_w[word] = lane_merge(build_w[word], data, sel);
      if (word == REG_CFG3W) build_w[word][31:16] = 16'h0000;
    end else begin
      e.exp = (word == REG_CFG3W) ? status_word(build_w[0][15:0]) : build_w[word];
    end
    table_q[n_entries] = e;
    n_entries++;
  endtask

  task automatic build_table();
    logic [3:0] masks [8];
    masks = '{4'hf, 4'h1, 4'h2, 4'h4, 4'h8, 4'h5, 4'ha, 4'h0};
    for (int w = 0; w < 4; w++) build_w[w] = '0;
    n_entries = 0;
    // Reset values
    for (int w = 1; w < 4; w++) add_entry(1'b0, w[1:0], 4'h0, 32'h0);
    // Random byte-lane writes with read-back
    for (int w = 1; w < 4; w++) begin
      for (int m = 0; m < 8; m++) begin
        add_entry(1'b1, w[1:0], masks[m], rand_word());
        add_entry(1'b0, w[1:0], 4'h0, 32'h0);
      end
    end
    // 3-wire word, upper lanes are read-only
    add_entry(1'b1, REG_CFG3W, 4'hf, rand_word());
    add_entry(1'b0, REG_CFG3W, 4'h0, 32'h0);
    add_entry(1'b1, REG_CFG3W, 4'hc, 32'hffff_ffff);
    add_entry(1'b0, REG_CFG3W, 4'h0, 32'h0);
    add_entry(1'b1, REG_CFG3W, 4'h3, 32'h0000_03a5);
    add_entry(1'b0, REG_CFG3W, 4'h0, 32'h0);
    // Strobes: raise, rewrite, clear and raise again
    add_entry(1'b1, REG_DLY_LO, 4'hf, 32'hffff_ffff);
    add_entry(1'b1, REG_DLY_LO, 4'hf, 32'hffff_ffff);
    add_entry(1'b1, REG_DLY_LO, 4'hf, 32'h0000_0000);
    add_entry(1'b1, REG_DLY_LO, 4'hf, 32'hffff_ffff);
    add_entry(1'b1, REG_CTRL, 4'h2, 32'h0000_0000);
    add_entry(1'b1, REG_CTRL, 4'h2, 32'h0000_ff00);
    add_entry(1'b1, REG_CTRL, 4'h2, 32'h0000_ff00);
    add_entry(1'b0, REG_CTRL, 4'h0, 32'h0);
  endtask

  // Ack is sampled on the falling edge
  task automatic wait_ack();
    int n;
    n = 0;
    do begin
      @(negedge wb_clk_i);
      n++;
    end while (!rsp.ack && n < 4);
    if (!rsp.ack) fail_now("no ack within 4 cycles");
  endtask

  task automatic bus_write(input logic [1:0] word, input logic [3:0] sel, input logic [31:0] d);
    wb_req_t r;
    r = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: {28'd0, word, 2'b00}, sel: sel, dat: d};
    @(posedge wb_clk_i);
    req <= r;
    wait_ack();
    @(posedge wb_clk_i);
    req <= '0;
  endtask

  task automatic bus_read(input logic [1:0] word, output logic [31:0] d);
    wb_req_t r;
    r = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: {28'd0, word, 2'b00}, sel: 4'hf, dat: '0};
    @(posedge wb_clk_i);
    req <= r;
    wait_ack();
    d = rsp.dat;
    @(posedge wb_clk_i);
    req <= '0;
  endtask

  // Expected pins of both boards from the stored word 0
  task automatic check_boards();
    adc3wire_t p0;
    adc3wire_t p1;
    p0 = '{sclk: run_w[0][9], sdata: run_w[0][8], csn: ~run_w[0][3:0]};
    p1 = '{sclk: run_w[0][9], sdata: run_w[0][8], csn: ~run_w[0][7:4]};
    check_pins("adc0_3w_o", adc0, p0);
    check_pins("adc1_3w_o", adc1, p1);
  endtask

  // Run one write row, then check levels and the strobe cycle
  task automatic apply_write(input entry_t e);
    logic [71:0] old_lvl;
    logic [71:0] new_lvl;
    logic [71:0] rise;
    old_lvl = {run_w[3], run_w[2], run_w[1][15:8]};
    run_w[e.word] = lane_merge(run_w[e.word], e.data, e.sel);
    if (e.word == REG_CFG3W) run_w[0][31:16] = 16'h0000;
    new_lvl = {run_w[3], run_w[2], run_w[1][15:8]};
    rise = new_lvl & ~old_lvl;
    for (int i = 0; i < 72; i++) exp_cnt[i] += int'(rise[i]);
    bus_write(e.word, e.sel, e.data);
    check_ctrl(ctrl_t'(run_w[1]));
    check_boards();
    // Pulse shows in the cycle after ack
    @(negedge wb_clk_i);
    check_word("bitslip_o", {24'd0, bitslip}, {24'd0, rise[7:0]});
    check_word("delay_rst_o[31:0]", delay_rst[31:0], rise[39:8]);
    check_word("delay_rst_o[63:32]", delay_rst[63:32], rise[71:40]);
  endtask

  // Pulse monitor and read data gating
  always @(negedge wb_clk_i) begin
    if (!wb_rst_i) begin
      for (int i = 0; i < 72; i++) pulse_cnt[i] += int'(pulse_vec[i]);
      if (!rsp.ack) check_word("wb_rsp_o.dat idle", rsp.dat, 32'h0);
      check_word("wb_rsp_o.err", {31'd0, rsp.err}, 32'h0);
    end
  end

  // Run limit from the table length
  always @(posedge wb_clk_i) begin
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      fail_now("simulation ran past its cycle limit");
    end
  end

  initial begin
    logic [31:0] rd;
    cycles = 0;
    cycle_limit = 0;
    lfsr_state = 32'h79f2_44c0;
    for (int i = 0; i < 72; i++) begin
      pulse_cnt[i] = 0;
      exp_cnt[i] = 0;
    end
    for (int w = 0; w < 4; w++) run_w[w] = '0;
    req <= '0;
    adc_locked <= LOCK_VAL;
    wb_rst_i <= 1'b1;
    build_table();
    cycle_limit = n_entries * 8 + 200;
    repeat (10) @(posedge wb_clk_i);
    wb_rst_i <= 1'b0;
    @(negedge wb_clk_i);
    // Reset state on the pins
    check_ctrl('0);
    check_boards();
    check_word("bitslip_o", {24'd0, bitslip}, 32'h0);
    check_word("delay_rst_o[31:0]", delay_rst[31:0], 32'h0);
    check_word("delay_rst_o[63:32]", delay_rst[63:32], 32'h0);
    for (int i = 0; i < n_entries; i++) begin
      if (table_q[i].wr) begin
        apply_write(table_q[i]);
      end else begin
        bus_read(table_q[i].word, rd);
        check_word($sformatf("read word %0d", table_q[i].word), rd, table_q[i].exp);
      end
    end
    repeat (3) @(posedge wb_clk_i);
    // Every raised bit pulsed exactly as often as expected
    for (int i = 0; i < 72; i++) begin
      check_word($sformatf("pulse count bit %0d", i), pulse_cnt[i], exp_cnt[i]);
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

/* sim.f */
verilog/adc16_ctrl_pkg.sv
verilog/adc16_strobe_gen.sv
verilog/wb_adc16_regs.sv
verilog/adc16_ctrl_top.sv
verification/adc16_ctrl_props.sv
verification/adc16_ctrl_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing --assert -j 0
TOP       ?= adc16_ctrl_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
